// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/dtlb.sv ====
`timescale 1ns/1ps

module dtlb import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic lookup_en,
    input  vpn_t lookup_vpn,
    input  logic flush,
    input  logic refill_en,
    input  vpn_t refill_vpn,
    input  pte_t refill_pte,
    input  logic refill_page_4m,
    output logic tlb_hit,
    output pte_t tlb_pte,
    output logic tlb_page_4m
);

    // Entry count is a power of two
    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic [TLB_ENTRIES-1:0] valid_q;
    logic [9:0]             vpn_1_q   [TLB_ENTRIES];
    logic [9:0]             vpn_0_q   [TLB_ENTRIES];
    logic                   page_4m_q [TLB_ENTRIES];
    pte_t                   pte_q     [TLB_ENTRIES];

    logic [IDX_W-1:0] lkp_idx;
    logic [IDX_W-1:0] ref_idx;
    logic             entry_match;

    assign lkp_idx = lookup_vpn[IDX_W-1:0];
    assign ref_idx = refill_vpn[IDX_W-1:0];   // Refill indexes by its own vpn

    // Superpage entries ignore vpn_0
    assign entry_match = valid_q[lkp_idx]
                      && (vpn_1_q[lkp_idx] == lookup_vpn[19:10])
                      && ((vpn_0_q[lkp_idx] == lookup_vpn[9:0]) || page_4m_q[lkp_idx]);

    assign tlb_hit     = lookup_en && entry_match;
    assign tlb_pte     = tlb_hit ? pte_q[lkp_idx] : '0;
    assign tlb_page_4m = tlb_hit && page_4m_q[lkp_idx];

    // Flush wins over refill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (refill_en) begin
            valid_q[ref_idx] <= 1'b1;
        end
    end

    // Entry contents
    always_ff @(posedge clk) begin
        if (refill_en && !flush) begin
            vpn_1_q[ref_idx]   <= refill_vpn[19:10];
            vpn_0_q[ref_idx]   <= refill_vpn[9:0];
            page_4m_q[ref_idx] <= refill_page_4m;
            pte_q[ref_idx]     <= refill_pte;
        end
    end

    // Flush is only legal while idle, refills only happen mid-walk
    a_no_flush_refill: assert property (
        @(posedge clk) disable iff (!rst_n) !(flush && refill_en)
    ) else $error("dtlb: flush and refill in the same cycle");

endmodule

// ==== source/mmu_ctrl.sv ====
`timescale 1ns/1ps

module mmu_ctrl import mmu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   trans_req,
    input  vaddr_t trans_vaddr,
    output logic   trans_done,
    output paddr_t trans_paddr,
    output logic   page_fault,
    output logic   busy,
    output logic   lookup_en,
    output vpn_t   lookup_vpn,
    input  logic   tlb_hit,
    input  pte_t   tlb_pte,
    input  logic   tlb_page_4m,
    output logic   walk_start,
    output vpn_t   walk_vpn,
    input  logic   refill_en,
    input  logic   walk_fault
);

    ctrl_state_t state_q;
    vaddr_t      vaddr_q;
    vaddr_t      cur_vaddr;
    paddr_t      hit_paddr;

    // Fresh address in IDLE and the held one otherwise
    assign cur_vaddr  = (state_q == CTRL_IDLE) ? trans_vaddr : vaddr_q;
    assign lookup_vpn = cur_vaddr[31:12];
    assign lookup_en  = ((state_q == CTRL_IDLE) && trans_req) || (state_q == CTRL_RETRY);
    assign walk_vpn   = vaddr_q[31:12];
    assign busy       = (state_q != CTRL_IDLE);

    // Superpage keeps vpn_0 from the virtual address
    assign hit_paddr = tlb_page_4m ? {tlb_pte[31:20], cur_vaddr[21:0]}
                                   : {tlb_pte[31:PTE_PPN_LSB], cur_vaddr[11:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= CTRL_IDLE;
            trans_done <= 1'b0;
            page_fault <= 1'b0;
            walk_start <= 1'b0;
        end else begin
            trans_done <= 1'b0;
            page_fault <= 1'b0;
            walk_start <= 1'b0;
            case (state_q)
                CTRL_IDLE: begin
                    if (trans_req && tlb_hit) begin
                        trans_done <= 1'b1;
                    end else if (trans_req) begin
                        walk_start <= 1'b1;
                        state_q    <= CTRL_WALK;
                    end
                end
                CTRL_WALK: begin
                    if (refill_en) begin
                        state_q <= CTRL_RETRY;
                    end else if (walk_fault) begin
                        trans_done <= 1'b1;
                        page_fault <= 1'b1;
                        state_q    <= CTRL_IDLE;
                    end
                end
                CTRL_RETRY: begin
                    if (tlb_hit) begin
                        trans_done <= 1'b1;
                        state_q    <= CTRL_IDLE;
                    end else begin
                        walk_start <= 1'b1;   // Entry was lost so walk again
                        state_q    <= CTRL_WALK;
                    end
                end
                default: state_q <= CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == CTRL_IDLE) && trans_req) begin
            vaddr_q <= trans_vaddr;
        end
        if (tlb_hit) begin
            trans_paddr <= hit_paddr;
        end else if ((state_q == CTRL_WALK) && walk_fault) begin
            trans_paddr <= '0;
        end
    end

    a_no_req_busy: assert property (
        @(posedge clk) disable iff (!rst_n) trans_req |-> !busy
    ) else $error("mmu_ctrl: trans_req while busy");

endmodule

// ==== source/mmu_pkg.sv ====
package mmu_pkg;

    // Address and page widths for Sv32
    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;
    typedef logic [19:0] vpn_t;   // vpn_1 in [19:10], vpn_0 in [9:0]
    typedef logic [21:0] ppn_t;
    typedef logic [31:0] pte_t;

    // PTE flag positions
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;

    // PPN field starts here and runs to bit 31
    localparam int PTE_PPN_LSB = 10;

    // Walker states, one request and one wait state per level
    typedef enum logic [2:0] {
        PTW_IDLE,
        PTW_L1_REQ,
        PTW_L1_WAIT,
        PTW_L0_REQ,
        PTW_L0_WAIT
    } ptw_state_t;

    // Request sequencer states
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_WALK,    // Waiting on the walker
        CTRL_RETRY    // Lookup again after a refill
    } ctrl_state_t;

endpackage

// ==== source/mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   trans_req,
    input  vaddr_t trans_vaddr,
    input  ppn_t   satp_ppn,
    input  logic   tlb_flush,
    output logic   trans_done,
    output paddr_t trans_paddr,
    output logic   page_fault,
    output logic   busy,
    output logic   mem_req,
    output paddr_t mem_addr,
    input  logic   mem_rvalid,
    input  pte_t   mem_rdata
);

    logic lookup_en;
    vpn_t lookup_vpn;
    logic tlb_hit;
    pte_t tlb_pte;
    logic tlb_page_4m;
    logic walk_start;
    vpn_t walk_vpn;
    logic refill_en;
    vpn_t refill_vpn;
    pte_t refill_pte;
    logic refill_page_4m;
    logic walk_fault;

    mmu_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .trans_req   (trans_req),
        .trans_vaddr (trans_vaddr),
        .trans_done  (trans_done),
        .trans_paddr (trans_paddr),
        .page_fault  (page_fault),
        .busy        (busy),
        .lookup_en   (lookup_en),
        .lookup_vpn  (lookup_vpn),
        .tlb_hit     (tlb_hit),
        .tlb_pte     (tlb_pte),
        .tlb_page_4m (tlb_page_4m),
        .walk_start  (walk_start),
        .walk_vpn    (walk_vpn),
        .refill_en   (refill_en),
        .walk_fault  (walk_fault)
    );

    dtlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_dtlb (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_en      (lookup_en),
        .lookup_vpn     (lookup_vpn),
        .flush          (tlb_flush),
        .refill_en      (refill_en),
        .refill_vpn     (refill_vpn),
        .refill_pte     (refill_pte),
        .refill_page_4m (refill_page_4m),
        .tlb_hit        (tlb_hit),
        .tlb_pte        (tlb_pte),
        .tlb_page_4m    (tlb_page_4m)
    );

    page_table_walker u_ptw (
        .clk            (clk),
        .rst_n          (rst_n),
        .satp_ppn       (satp_ppn),
        .walk_start     (walk_start),
        .walk_vpn       (walk_vpn),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_rvalid     (mem_rvalid),
        .mem_rdata      (mem_rdata),
        .refill_en      (refill_en),
        .refill_vpn     (refill_vpn),
        .refill_pte     (refill_pte),
        .refill_page_4m (refill_page_4m),
        .walk_fault     (walk_fault)
    );

    // Flush must not land in the middle of a translation
    a_no_flush_busy: assert property (
        @(posedge clk) disable iff (!rst_n) tlb_flush |-> !busy
    ) else $error("mmu_top: tlb_flush while busy");

endmodule

// ==== source/page_table_walker.sv ====
`timescale 1ns/1ps

module page_table_walker import mmu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  ppn_t   satp_ppn,
    input  logic   walk_start,
    input  vpn_t   walk_vpn,
    output logic   mem_req,
    output paddr_t mem_addr,
    input  logic   mem_rvalid,
    input  pte_t   mem_rdata,
    output logic   refill_en,
    output vpn_t   refill_vpn,
    output pte_t   refill_pte,
    output logic   refill_page_4m,
    output logic   walk_fault
);

    ptw_state_t state_q;
    vpn_t       vpn_q;
    ppn_t       l0_ppn_q;   // Next table base from the level-1 PTE
    logic       pte_valid;
    logic       pte_leaf;
    logic       in_wait;

    assign pte_valid = mem_rdata[PTE_V];
    assign pte_leaf  = mem_rdata[PTE_R] | mem_rdata[PTE_X];
    assign in_wait   = (state_q == PTW_L1_WAIT) || (state_q == PTW_L0_WAIT);

    // One read per REQ state
    assign mem_req = (state_q == PTW_L1_REQ) || (state_q == PTW_L0_REQ);

    // Table base times 4096 plus index times 4
    assign mem_addr = (state_q == PTW_L0_REQ) ? {l0_ppn_q, vpn_q[9:0], 2'b00}
                                              : {satp_ppn, vpn_q[19:10], 2'b00};

    assign refill_vpn = vpn_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= PTW_IDLE;
            refill_en  <= 1'b0;
            walk_fault <= 1'b0;
        end else begin
            refill_en  <= 1'b0;
            walk_fault <= 1'b0;
            case (state_q)
                PTW_IDLE: begin
                    if (walk_start) begin
                        state_q <= PTW_L1_REQ;
                    end
                end
                PTW_L1_REQ: state_q <= PTW_L1_WAIT;
                PTW_L1_WAIT: begin
                    if (mem_rvalid) begin
                        if (!pte_valid) begin
                            walk_fault <= 1'b1;
                            state_q    <= PTW_IDLE;
                        end else if (pte_leaf) begin
                            refill_en <= 1'b1;   // Superpage
                            state_q   <= PTW_IDLE;
                        end else begin
                            state_q <= PTW_L0_REQ;
                        end
                    end
                end
                PTW_L0_REQ: state_q <= PTW_L0_WAIT;
                PTW_L0_WAIT: begin
                    if (mem_rvalid) begin
                        // Pointer at level 0 counts as a fault too
                        if (pte_valid && pte_leaf) begin
                            refill_en <= 1'b1;
                        end else begin
                            walk_fault <= 1'b1;
                        end
                        state_q <= PTW_IDLE;
                    end
                end
                default: state_q <= PTW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == PTW_IDLE) && walk_start) begin
            vpn_q <= walk_vpn;
        end
        if ((state_q == PTW_L1_WAIT) && mem_rvalid) begin
            l0_ppn_q       <= mem_rdata[31:PTE_PPN_LSB];
            refill_pte     <= mem_rdata;
            refill_page_4m <= 1'b1;
        end
        if ((state_q == PTW_L0_WAIT) && mem_rvalid) begin
            refill_pte     <= mem_rdata;
            refill_page_4m <= 1'b0;
        end
    end

    // Memory answers only the one outstanding read
    a_rvalid_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n) mem_rvalid |-> in_wait
    ) else $error("ptw: mem_rvalid outside a wait state");

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) walk_start |-> (state_q == PTW_IDLE)
    ) else $error("ptw: walk_start while a walk is running");

endmodule

// ==== verif/mmu_stim.txt ====
# M addr pte | S satp_ppn | F flush
# T name vaddr exp_paddr exp_fault exp_reads (hex, hex, hex, dec, dec)
S 000001
M 1004 00000801
M 200C 048D1407
M 10C8 ABC0000F
M 100C 00000C00
M 1010 00000C01
M 301C 00000006
M 3020 00000401
M 201C 002AF003
M 2010 0FC3C003
T a_walk 00403123 012345123 0 2
T a_hit 00403123 012345123 0 0
T sp_walk 0C801ABC 2AF001ABC 0 1
T sp_hit 0C805444 2AF005444 0 0
T l1_fault 00C02010 000000000 1 1
T l1_fault_again 00C02010 000000000 1 1
T l0_fault 01007008 000000000 1 2
T l0_fault_again 01007008 000000000 1 2
T l0_ptr_fault 01008000 000000000 1 2
F
T a_after_flush 00403123 012345123 0 2
T a_hit2 00403123 012345123 0 0
T c_evict_a 00407FF0 000ABCFF0 0 2
T a_evict_c 00403123 012345123 0 2
T c_evict_a2 00407FF0 000ABCFF0 0 2
T d_walk 00404800 03F0F0800 0 2
T b_walk 0C801ABC 2AF001ABC 0 1
T c_hit 00407FF0 000ABCFF0 0 0
T d_hit 00404800 03F0F0800 0 0
T b_hit 0C805444 2AF005444 0 0

// ==== verif/mmu_tb.sv ====
`timescale 1ns/1ps

module mmu_tb import mmu_pkg::*; ();

    logic   clk;
    logic   rst_n;
    logic   trans_req;
    vaddr_t trans_vaddr;
    ppn_t   satp_ppn;
    logic   tlb_flush;
    logic   trans_done;
    paddr_t trans_paddr;
    logic   page_fault;
    logic   busy;
    logic   mem_req;
    paddr_t mem_addr;
    logic   mem_rvalid = 1'b0;   // Owned by the memory model
    pte_t   mem_rdata  = '0;

    // Memory model state
    pte_t   mem_words [paddr_t];
    logic   pending    = 1'b0;
    paddr_t pend_addr  = '0;
    int     lat_left   = 0;
    int     read_total = 0;
    int     mem_errors = 0;

    string  stim_lines [$];
    int     error_count = 0;
    int     test_count  = 0;
    int     cycle_count = 0;
    int     cycle_limit = 100;

    mmu_top #(
        .TLB_ENTRIES (4)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .trans_req   (trans_req),
        .trans_vaddr (trans_vaddr),
        .satp_ppn    (satp_ppn),
        .tlb_flush   (tlb_flush),
        .trans_done  (trans_done),
        .trans_paddr (trans_paddr),
        .page_fault  (page_fault),
        .busy        (busy),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

    always #2 clk = ~clk;

    // Unmapped words read back as an invalid pattern built from the address
    function automatic pte_t read_word(input paddr_t addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end else begin
            return (addr[33:2] ^ {30'd0, addr[1:0]}) & 32'hFFFF_FFFE;
        end
    endfunction

    // One read in flight that is answered 1 to 4 cycles later
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_rvalid = 1'b0;
            pending    = 1'b0;
        end else begin
            mem_rvalid = 1'b0;
            if (pending) begin
                if (lat_left <= 1) begin
                    mem_rvalid = 1'b1;
                    mem_rdata  = read_word(pend_addr);
                    pending    = 1'b0;
                end else begin
                    lat_left = lat_left - 1;
                end
            end
            if (mem_req) begin
                if (pending) begin
                    mem_errors = mem_errors + 1;
                    $display("ERROR: memory request issued while a read was still outstanding");
                end
                pending    = 1'b1;
                pend_addr  = mem_addr;
                lat_left   = $urandom_range(1, 4);
                read_total = read_total + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("ERROR: simulation timed out after %0d cycles", cycle_count);
            $display("Tests run: %0d, errors: %0d", test_count,
                     error_count + mem_errors + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic compare_value(input string test_name, input string field,
                                 input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s %s: expected %0h, actual %0h",
                     test_name, field, expected, actual);
        end
    endtask

    task automatic load_stim_file();
        int    fd;
        string line;
        string tag;
        fd = $fopen("verif/mmu_stim.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("ERROR: could not open the stimulus file verif/mmu_stim.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%s", tag) == 1 && tag.getc(0) != 8'h23) begin
                    stim_lines.push_back(line);   // Comments and blanks dropped
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_translation(input string name, input vaddr_t vaddr,
                                   input paddr_t exp_paddr, input int exp_fault,
                                   input int exp_reads);
        int   reads_before;
        int   latency;
        logic busy_early;
        while (busy) begin
            @(negedge clk);
        end
        reads_before = read_total;
        trans_vaddr  = vaddr;
        trans_req    = 1'b1;
        @(negedge clk);
        trans_req  = 1'b0;
        latency    = 1;
        busy_early = busy;   // A miss holds busy while it walks
        while (!trans_done) begin
            @(negedge clk);
            latency++;
        end
        test_count++;
        compare_value(name, "paddr", 64'(exp_paddr), 64'(trans_paddr));
        compare_value(name, "fault", 64'(exp_fault), 64'(page_fault));
        compare_value(name, "reads", 64'(exp_reads), 64'(read_total - reads_before));
        compare_value(name, "busy_walk", 64'(exp_reads != 0), 64'(busy_early));
        compare_value(name, "busy_done", 64'd0, 64'(busy));
        if (exp_reads == 0) begin
            compare_value(name, "latency", 64'd1, 64'(latency));   // Hit path
        end
    endtask

    task automatic run_stim_line(input string line);
        string  tag;
        string  name;
        paddr_t addr;
        pte_t   data;
        ppn_t   ppn;
        vaddr_t vaddr;
        paddr_t exp_paddr;
        int     exp_fault;
        int     exp_reads;
        int     n;
        n = $sscanf(line, "%s", tag);
        if (tag == "M") begin
            n = $sscanf(line, "%s %h %h", tag, addr, data);
            mem_words[addr] = data;
        end else if (tag == "S") begin
            n = $sscanf(line, "%s %h", tag, ppn);
            satp_ppn = ppn;
        end else if (tag == "F") begin
            while (busy) begin
                @(negedge clk);
            end
            tlb_flush = 1'b1;
            @(negedge clk);
            tlb_flush = 1'b0;
        end else if (tag == "T") begin
            n = $sscanf(line, "%s %s %h %h %d %d", tag, name, vaddr, exp_paddr,
                        exp_fault, exp_reads);
            if (n != 6) begin
                error_count++;
                $display("ERROR: translation line has missing fields: %s", line);
            end else begin
                run_translation(name, vaddr, exp_paddr, exp_fault, exp_reads);
            end
        end else begin
            error_count++;
            $display("ERROR: unknown stimulus command %s", tag);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        trans_req   = 1'b0;
        trans_vaddr = '0;
        satp_ppn    = '0;
        tlb_flush   = 1'b0;
        void'($urandom(78595));
        load_stim_file();
        cycle_limit = 40 * stim_lines.size() + 100;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (stim_lines[i]) begin
            run_stim_line(stim_lines[i]);
        end
        repeat (2) @(negedge clk);   // Let the last done settle

        error_count = error_count + mem_errors;
        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/mmu_pkg.sv
source/dtlb.sv
source/page_table_walker.sv
source/mmu_ctrl.sv
source/mmu_top.sv
verif/mmu_tb.sv
